//--- Bender.yml
package:
  name: mac_switch

sources:
  - logic/eth_pkg.sv
  - logic/route_pkg.sv
  - logic/src_mac_tap.sv
  - logic/route_table.sv
  - logic/dest_lookup.sv
  - logic/pkt_fanout.sv
  - logic/egress_arbiter.sv
  - logic/mac_switch.sv
  - target: test
    files:
      - testbench/tb_mac_switch.sv

//--- files.f
logic/eth_pkg.sv
logic/route_pkg.sv
logic/src_mac_tap.sv
logic/route_table.sv
logic/dest_lookup.sv
logic/pkt_fanout.sv
logic/egress_arbiter.sv
logic/mac_switch.sv
testbench/tb_mac_switch.sv

//--- logic/dest_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module dest_lookup #(
	parameter int NETH = 4
) (
	input wire i_clk,
	input wire i_rst_n,
	// Beats from the source MAC tap
	input wire i_valid,
	output logic o_ready,
	input wire eth_pkg::beat_t i_data,
	input wire eth_pkg::bytes_t i_bytes,
	input wire i_last,
	// Address table request and answer
	output logic o_lookup,
	output eth_pkg::mac_t o_lookup_mac,
	input wire i_lookup_ack,
	input wire [NETH-1:0] i_lookup_mask,
	// Beats tagged with their egress mask
	output logic o_valid,
	input wire i_ready,
	output eth_pkg::beat_t o_data,
	output eth_pkg::bytes_t o_bytes,
	output logic o_last,
	output logic [NETH-1:0] o_mask
);
	import eth_pkg::*;

	typedef enum logic [1:0] {st_idle, st_req, st_wait, st_fwd} state_t;

	state_t state;
	logic fwd;
	logic [NETH-1:0] mask_q;

	assign fwd = (state == st_fwd);

	// Destination MAC sits in the first beat, held while it waits
	assign o_lookup = (state == st_req);
	assign o_lookup_mac = i_data[DST_MAC_MSB -: MACW];

	// Beats only move once the mask is known
	assign o_valid = fwd && i_valid;
	assign o_ready = fwd && i_ready;
	assign o_data = i_data;
	assign o_bytes = i_bytes;
	assign o_last = i_last;
	assign o_mask = mask_q;

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
			state <= st_idle;
		else
		begin
			case (state)
				st_idle:
					if (i_valid)
						state <= st_req;
				st_req:
					state <= st_wait;
				st_wait:
					if (i_lookup_ack)
						state <= st_fwd;
				default:
					// Mask held until the last beat leaves
					if (i_valid && i_ready && i_last)
						state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (state == st_wait && i_lookup_ack)
			mask_q <= i_lookup_mask;
	end

	// From the table answer until the packet ends, no new request
	a_one_req_per_pkt: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_lookup_ack |=> (!o_lookup until_with (o_valid && i_ready && o_last)));

endmodule

`default_nettype wire

//--- logic/egress_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module egress_arbiter #(
	parameter int NETH = 4
) (
	input wire i_clk,
	input wire i_rst_n,
	// One input per fanout, payload flattened
	input wire [NETH-1:0] i_s_valid,
	output logic [NETH-1:0] o_s_ready,
	input wire [NETH*eth_pkg::BEATW-1:0] i_s_data,
	input wire [NETH*eth_pkg::BYTEW-1:0] i_s_bytes,
	input wire [NETH-1:0] i_s_last,
	// Egress port
	output logic o_m_valid,
	input wire i_m_ready,
	output eth_pkg::beat_t o_m_data,
	output eth_pkg::bytes_t o_m_bytes,
	output logic o_m_last
);
	import eth_pkg::*;

	localparam int PORTW = (NETH > 1) ? $clog2(NETH) : 1;

	// Held grant, zero when idle
	logic [NETH-1:0] grant_q;
	logic [NETH-1:0] pick;
	logic [NETH-1:0] grant;
	// Winner of the previous packet
	logic [PORTW-1:0] last_q;
	logic [PORTW-1:0] sel;

	// Round robin, starting just after the last winner
	always_comb
	begin
		pick = '0;
		for (int k = NETH; k >= 1; k--)
			if (i_s_valid[(int'(last_q) + k) % NETH])
				pick = NETH'(1) << ((int'(last_q) + k) % NETH);
	end

	assign grant = (grant_q != '0) ? grant_q : pick;

	always_comb
	begin
		sel = '0;
		for (int i = 0; i < NETH; i++)
			if (grant[i])
				sel = PORTW'(i);
	end

	// Output follows the granted input
	assign o_m_valid = |(grant & i_s_valid);
	assign o_s_ready = grant & {NETH{i_m_ready}};
	assign o_m_data = i_s_data[sel*BEATW +: BEATW];
	assign o_m_bytes = i_s_bytes[sel*BYTEW +: BYTEW];
	assign o_m_last = i_s_last[sel];

	// Grant stays put from the first offer until the last beat leaves
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			grant_q <= '0;
			last_q <= '0;
		end
		else if (o_m_valid && i_m_ready && o_m_last)
		begin
			grant_q <= '0;
			last_q <= sel;
		end
		else
			grant_q <= grant;
	end

	a_grant_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$onehot0(grant));

endmodule

`default_nettype wire

//--- logic/eth_pkg.sv
`default_nettype none

package eth_pkg;

	// Beat format on every packet stream
	localparam int BEATW = 128;
	// Byte 0 of the packet sits in the top byte of the beat
	typedef logic [BEATW-1:0] beat_t;

	// Valid bytes in a last beat
	// Zero stands for a full beat of 16 bytes
	localparam int BYTEW = 4;
	typedef logic [BYTEW-1:0] bytes_t;

	// MAC addresses
	localparam int MACW = 48;
	typedef logic [MACW-1:0] mac_t;
	localparam mac_t BCAST_MAC = '1;

	// Header fields within the first beat
	// Destination in bytes 0 to 5, source in bytes 6 to 11
	localparam int DST_MAC_MSB = BEATW - 1;
	localparam int SRC_MAC_MSB = BEATW - 1 - MACW;

endpackage

`default_nettype wire

//--- logic/mac_switch.sv
`timescale 1ns/1ps
`default_nettype none

module mac_switch #(
	parameter int NETH = route_pkg::DEF_NETH,
	parameter int LGTBL = route_pkg::DEF_LGTBL,
	parameter int LGTIMEOUT = route_pkg::DEF_LGTIMEOUT
) (
	input wire i_clk,
	input wire i_rst_n,
	// Ingress, one slice per port
	input wire [NETH-1:0] i_rx_valid,
	output logic [NETH-1:0] o_rx_ready,
	input wire [NETH*eth_pkg::BEATW-1:0] i_rx_data,
	input wire [NETH*eth_pkg::BYTEW-1:0] i_rx_bytes,
	input wire [NETH-1:0] i_rx_last,
	// Egress, one slice per port
	output logic [NETH-1:0] o_tx_valid,
	input wire [NETH-1:0] i_tx_ready,
	output logic [NETH*eth_pkg::BEATW-1:0] o_tx_data,
	output logic [NETH*eth_pkg::BYTEW-1:0] o_tx_bytes,
	output logic [NETH-1:0] o_tx_last
);
	import eth_pkg::*;

	// Learn notices, broadcast to every table
	logic [NETH-1:0] learn;
	logic [NETH*MACW-1:0] learn_mac;

	// Crossbar, bit q*NETH+p is lane p of fanout q
	logic [NETH*NETH-1:0] xb_valid;
	logic [NETH*NETH-1:0] xb_ready;
	// Fanout payload is shared by all of its lanes
	logic [NETH*BEATW-1:0] fo_data;
	logic [NETH*BYTEW-1:0] fo_bytes;
	logic [NETH-1:0] fo_last;

	for (genvar p = 0; p < NETH; p++)
	begin : g_lane
		logic tap_valid;
		logic tap_ready;
		beat_t tap_data;
		bytes_t tap_bytes;
		logic tap_last;
		logic lookup;
		mac_t lookup_mac;
		logic lookup_ack;
		logic [NETH-1:0] lookup_mask;
		logic lk_valid;
		logic lk_ready;
		beat_t lk_data;
		bytes_t lk_bytes;
		logic lk_last;
		logic [NETH-1:0] lk_mask;
		logic [NETH-1:0] arb_valid;
		logic [NETH-1:0] arb_ready;

		//////////////////////////////
		// Ingress side
		//////////////////////////////

		src_mac_tap u_tap (
			.i_clk(i_clk),
			.i_rst_n(i_rst_n),
			.i_valid(i_rx_valid[p]),
			.o_ready(o_rx_ready[p]),
			.i_data(i_rx_data[p*BEATW +: BEATW]),
			.i_bytes(i_rx_bytes[p*BYTEW +: BYTEW]),
			.i_last(i_rx_last[p]),
			.o_valid(tap_valid),
			.i_ready(tap_ready),
			.o_data(tap_data),
			.o_bytes(tap_bytes),
			.o_last(tap_last),
			.o_learn(learn[p]),
			.o_learn_mac(learn_mac[p*MACW +: MACW])
		);

		route_table #(
			.NETH(NETH),
			.PORT_ID(p),
			.LGTBL(LGTBL),
			.LGTIMEOUT(LGTIMEOUT)
		) u_table (
			.i_clk(i_clk),
			.i_rst_n(i_rst_n),
			.i_learn(learn),
			.i_learn_mac(learn_mac),
			.i_lookup(lookup),
			.i_lookup_mac(lookup_mac),
			.o_lookup_ack(lookup_ack),
			.o_lookup_mask(lookup_mask)
		);

		dest_lookup #(
			.NETH(NETH)
		) u_lookup (
			.i_clk(i_clk),
			.i_rst_n(i_rst_n),
			.i_valid(tap_valid),
			.o_ready(tap_ready),
			.i_data(tap_data),
			.i_bytes(tap_bytes),
			.i_last(tap_last),
			.o_lookup(lookup),
			.o_lookup_mac(lookup_mac),
			.i_lookup_ack(lookup_ack),
			.i_lookup_mask(lookup_mask),
			.o_valid(lk_valid),
			.i_ready(lk_ready),
			.o_data(lk_data),
			.o_bytes(lk_bytes),
			.o_last(lk_last),
			.o_mask(lk_mask)
		);

		pkt_fanout #(
			.NETH(NETH)
		) u_fanout (
			.i_clk(i_clk),
			.i_rst_n(i_rst_n),
			.i_s_valid(lk_valid),
			.o_s_ready(lk_ready),
			.i_s_data(lk_data),
			.i_s_bytes(lk_bytes),
			.i_s_last(lk_last),
			.i_s_mask(lk_mask),
			.o_m_valid(xb_valid[p*NETH +: NETH]),
			.i_m_ready(xb_ready[p*NETH +: NETH]),
			.o_m_data(fo_data[p*BEATW +: BEATW]),
			.o_m_bytes(fo_bytes[p*BYTEW +: BYTEW]),
			.o_m_last(fo_last[p])
		);

		//////////////////////////////
		// Egress side
		//////////////////////////////

		// Input q of this arbiter is lane p of fanout q
		for (genvar q = 0; q < NETH; q++)
		begin : g_xbar
			assign arb_valid[q] = xb_valid[q*NETH + p];
			assign xb_ready[q*NETH + p] = arb_ready[q];
		end

		egress_arbiter #(
			.NETH(NETH)
		) u_arbiter (
			.i_clk(i_clk),
			.i_rst_n(i_rst_n),
			.i_s_valid(arb_valid),
			.o_s_ready(arb_ready),
			.i_s_data(fo_data),
			.i_s_bytes(fo_bytes),
			.i_s_last(fo_last),
			.o_m_valid(o_tx_valid[p]),
			.i_m_ready(i_tx_ready[p]),
			.o_m_data(o_tx_data[p*BEATW +: BEATW]),
			.o_m_bytes(o_tx_bytes[p*BYTEW +: BYTEW]),
			.o_m_last(o_tx_last[p])
		);
	end

endmodule

`default_nettype wire

//--- logic/pkt_fanout.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_fanout #(
	parameter int NETH = 4
) (
	input wire i_clk,
	input wire i_rst_n,
	// Tagged beats from the lookup
	input wire i_s_valid,
	output logic o_s_ready,
	input wire eth_pkg::beat_t i_s_data,
	input wire eth_pkg::bytes_t i_s_bytes,
	input wire i_s_last,
	input wire [NETH-1:0] i_s_mask,
	// One lane per egress port, shared payload
	output logic [NETH-1:0] o_m_valid,
	input wire [NETH-1:0] i_m_ready,
	output eth_pkg::beat_t o_m_data,
	output eth_pkg::bytes_t o_m_bytes,
	output logic o_m_last
);
	// Lanes that already took the current beat
	logic [NETH-1:0] done;
	// Lanes still owed the current beat
	logic [NETH-1:0] pending;

	assign pending = i_s_mask & ~done;
	assign o_m_valid = pending & {NETH{i_s_valid}};

	// Beat completes once every owed lane takes it
	// An empty mask completes at once and the beat is dropped
	assign o_s_ready = &(~pending | i_m_ready);

	assign o_m_data = i_s_data;
	assign o_m_bytes = i_s_bytes;
	assign o_m_last = i_s_last;

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
			done <= '0;
		else if (i_s_valid && o_s_ready)
			done <= '0;
		else if (i_s_valid)
			done <= done | (o_m_valid & i_m_ready);
	end

	// A lane that took a stalled beat is not offered it again
	a_no_repeat: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_s_valid && !o_s_ready) |=> ((o_m_valid & $past(o_m_valid & i_m_ready)) == '0));

endmodule

`default_nettype wire

//--- logic/route_pkg.sv
`default_nettype none

package route_pkg;

	// Number of Ethernet ports on the switch
	localparam int DEF_NETH = 4;

	// Log2 of the address table depth, 8 entries
	localparam int DEF_LGTBL = 3;

	// Log2 of the entry lifetime in clock cycles
	// An entry not refreshed for 2^20 cycles is forgotten
	localparam int DEF_LGTIMEOUT = 20;

endpackage

`default_nettype wire

//--- logic/route_table.sv
`timescale 1ns/1ps
`default_nettype none

module route_table #(
	parameter int NETH = 4,
	parameter int PORT_ID = 0,
	parameter int LGTBL = 3,
	parameter int LGTIMEOUT = 20
) (
	input wire i_clk,
	input wire i_rst_n,
	// Learn strobes from every ingress tap
	input wire [NETH-1:0] i_learn,
	input wire [NETH*eth_pkg::MACW-1:0] i_learn_mac,
	// Lookup from this lane
	input wire i_lookup,
	input wire eth_pkg::mac_t i_lookup_mac,
	output logic o_lookup_ack,
	output logic [NETH-1:0] o_lookup_mask
);
	import eth_pkg::*;

	localparam int NTBL = 1 << LGTBL;
	localparam int PORTW = (NETH > 1) ? $clog2(NETH) : 1;
	// Flood set, every port but our own
	localparam logic [NETH-1:0] OTHERS = ~(NETH'(1) << PORT_ID);

	// Table entries
	logic [NTBL-1:0] tbl_valid;
	mac_t tbl_mac [NTBL];
	logic [PORTW-1:0] tbl_port [NTBL];
	logic [LGTIMEOUT:0] tbl_ts [NTBL];
	logic [LGTIMEOUT:0] age [NTBL];
	// Free running time base
	logic [LGTIMEOUT:0] now;

	// One pending learn slot per source port
	logic [NETH-1:0] pend_valid;
	mac_t pend_mac [NETH];
	logic [NETH-1:0] svc_mask;

	logic lrn_go;
	logic [PORTW-1:0] lrn_src;
	mac_t lrn_mac;
	logic lrn_hit;
	logic lrn_free;
	logic [LGTBL-1:0] hit_idx;
	logic [LGTBL-1:0] free_idx;
	logic [LGTBL-1:0] old_idx;
	logic [LGTIMEOUT:0] old_age;
	logic [LGTBL-1:0] wr_idx;

	logic lk_hit;
	logic [PORTW-1:0] lk_port;
	logic [NETH-1:0] next_mask;

	// Two live entries holding the same address
	logic dup_mac;

	// Age wraps at 2^(LGTIMEOUT+1), so entries are dropped before that
	always_comb
		for (int e = 0; e < NTBL; e++)
			age[e] = now - tbl_ts[e];

	//////////////////////////////
	// Learning
	//////////////////////////////

	// Lowest pending source first
	always_comb
	begin
		lrn_go = 1'b0;
		lrn_src = '0;
		for (int s = NETH - 1; s >= 0; s--)
			if (pend_valid[s])
			begin
				lrn_go = 1'b1;
				lrn_src = PORTW'(s);
			end
	end

	assign lrn_mac = pend_mac[lrn_src];
	assign svc_mask = lrn_go ? (NETH'(1) << lrn_src) : '0;

	// Slot choice: refresh a match, else fill a free slot, else evict the oldest
	always_comb
	begin
		lrn_hit = 1'b0;
		lrn_free = 1'b0;
		hit_idx = '0;
		free_idx = '0;
		old_idx = '0;
		old_age = '0;
		for (int e = NTBL - 1; e >= 0; e--)
		begin
			if (tbl_valid[e] && tbl_mac[e] == lrn_mac)
			begin
				lrn_hit = 1'b1;
				hit_idx = LGTBL'(e);
			end
			if (!tbl_valid[e] || age[e][LGTIMEOUT])
			begin
				lrn_free = 1'b1;
				free_idx = LGTBL'(e);
			end
			if (age[e] >= old_age)
			begin
				old_age = age[e];
				old_idx = LGTBL'(e);
			end
		end
	end

	assign wr_idx = lrn_hit ? hit_idx : (lrn_free ? free_idx : old_idx);

	//////////////////////////////
	// Lookup
	//////////////////////////////

	always_comb
	begin
		lk_hit = 1'b0;
		lk_port = '0;
		for (int e = 0; e < NTBL; e++)
			if (tbl_valid[e] && !age[e][LGTIMEOUT] && tbl_mac[e] == i_lookup_mac)
			begin
				lk_hit = 1'b1;
				lk_port = tbl_port[e];
			end
		// Broadcast and unknown addresses flood
		if (i_lookup_mac == BCAST_MAC || !lk_hit)
			next_mask = OTHERS;
		else
			next_mask = (NETH'(1) << lk_port) & OTHERS;
	end

	// Control state
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			now <= '0;
			tbl_valid <= '0;
			pend_valid <= '0;
			o_lookup_ack <= 1'b0;
		end
		else
		begin
			now <= now + 1'b1;
			// A newer strobe replaces a slot in service
			pend_valid <= i_learn | (pend_valid & ~svc_mask);
			o_lookup_ack <= i_lookup;
			for (int e = 0; e < NTBL; e++)
				if (age[e][LGTIMEOUT])
					tbl_valid[e] <= 1'b0;
			if (lrn_go)
				tbl_valid[wr_idx] <= 1'b1;
		end
	end

	// Entry contents and lookup answer
	always_ff @(posedge i_clk)
	begin
		for (int s = 0; s < NETH; s++)
			if (i_learn[s])
				pend_mac[s] <= i_learn_mac[s*MACW +: MACW];
		if (lrn_go)
		begin
			tbl_mac[wr_idx] <= lrn_mac;
			tbl_port[wr_idx] <= lrn_src;
			tbl_ts[wr_idx] <= now;
		end
		o_lookup_mask <= next_mask;
	end

	// Pairwise compare of all live entries
	always_comb
	begin
		dup_mac = 1'b0;
		for (int a = 0; a < NTBL; a++)
			for (int b = a + 1; b < NTBL; b++)
				if (tbl_valid[a] && tbl_valid[b] && tbl_mac[a] == tbl_mac[b])
					dup_mac = 1'b1;
	end

	// A learn refreshes its match, so an address never holds two entries
	a_unique_mac: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!dup_mac);

endmodule

`default_nettype wire

//--- logic/src_mac_tap.sv
`timescale 1ns/1ps
`default_nettype none

module src_mac_tap (
	input wire i_clk,
	input wire i_rst_n,
	// Ingress beats
	input wire i_valid,
	output logic o_ready,
	input wire eth_pkg::beat_t i_data,
	input wire eth_pkg::bytes_t i_bytes,
	input wire i_last,
	// Beats on to the destination lookup
	output logic o_valid,
	input wire i_ready,
	output eth_pkg::beat_t o_data,
	output eth_pkg::bytes_t o_bytes,
	output logic o_last,
	// Learn notice for all address tables
	output logic o_learn,
	output eth_pkg::mac_t o_learn_mac
);
	import eth_pkg::*;

	// High while the next beat starts a packet
	logic first;
	logic xfer;

	// Stream passes straight through
	assign o_valid = i_valid;
	assign o_ready = i_ready;
	assign o_data = i_data;
	assign o_bytes = i_bytes;
	assign o_last = i_last;

	assign xfer = i_valid && i_ready;

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
			first <= 1'b1;
		else if (xfer)
			first <= i_last;
	end

	// Source MAC, bytes 6 to 11 of the first beat
	assign o_learn_mac = i_data[SRC_MAC_MSB -: MACW];
	// One strobe per packet, in the cycle its first beat moves
	assign o_learn = first && xfer;

endmodule

`default_nettype wire

//--- testbench/tb_mac_switch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mac_switch;
	import eth_pkg::*;

	localparam int NETH = 4;
	localparam int LGTBL = 3;
	localparam int LGTIMEOUT = 6;
	localparam int SEED = 94;
	// Cycles any single wait may take
	localparam int WAIT_LIMIT = 400;
	// Beat slots per packet in the keyed stores
	localparam int MAXB = 64;
	localparam mac_t MAC_U = 48'h0a_bb_cc_dd_ee_01;

	logic i_clk;
	logic i_rst_n;
	logic [NETH-1:0] i_rx_valid;
	logic [NETH-1:0] o_rx_ready;
	logic [NETH*BEATW-1:0] i_rx_data;
	logic [NETH*BYTEW-1:0] i_rx_bytes;
	logic [NETH-1:0] i_rx_last;
	logic [NETH-1:0] o_tx_valid;
	logic [NETH-1:0] i_tx_ready;
	logic [NETH*BEATW-1:0] o_tx_data;
	logic [NETH*BYTEW-1:0] o_tx_bytes;
	logic [NETH-1:0] o_tx_last;

	// Model table, MAC to port and the cycle it was learned
	int model_port [mac_t];
	longint model_time [mac_t];
	// Expected packets by id
	int exp_len [int];
	logic [NETH-1:0] exp_mask [int];
	beat_t exp_beat [int];
	// Received packets, keyed by id*NETH+port
	int rx_len [int];
	beat_t rx_beat [int];
	int rx_cnt [NETH];
	int cur_id [NETH];
	int cur_k [NETH];

	int test_ids [$];
	string test_name;
	longint cycle;
	int next_id;
	int errors;
	int err_before;
	int tests_run;
	int tests_passed;
	int want_total;
	int seed;
	logic ready_random;
	logic compare_busy;
	event compare_req;

	mac_switch #(
		.NETH(NETH),
		.LGTBL(LGTBL),
		.LGTIMEOUT(LGTIMEOUT)
	) i_dut (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_rx_valid(i_rx_valid),
		.o_rx_ready(o_rx_ready),
		.i_rx_data(i_rx_data),
		.i_rx_bytes(i_rx_bytes),
		.i_rx_last(i_rx_last),
		.o_tx_valid(o_tx_valid),
		.i_tx_ready(i_tx_ready),
		.o_tx_data(o_tx_data),
		.o_tx_bytes(o_tx_bytes),
		.o_tx_last(o_tx_last)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	always @(posedge i_clk)
		cycle++;

	// Egress back-pressure, random only during the contention test
	always @(negedge i_clk)
	begin
		for (int p = 0; p < NETH; p++)
			i_tx_ready[p] = ready_random ? (($urandom % 4) != 0) : 1'b1;
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Source MAC used by each ingress port
	function automatic mac_t port_mac(input int p);
		return 48'h02_00_5e_00_00_10 + mac_t'(p);
	endfunction

	// Broadcast floods, a live entry picks its port, anything else floods
	function automatic logic [NETH-1:0] expected_mask(input int src_port, input mac_t dst);
		logic [NETH-1:0] others;
		others = ~(NETH'(1) << src_port);
		if (dst == BCAST_MAC)
			return others;
		if (model_port.exists(dst) && (cycle - model_time[dst]) < (longint'(1) << LGTIMEOUT))
			return (NETH'(1) << model_port[dst]) & others;
		return others;
	endfunction

	function automatic int rx_total();
		int t;
		t = 0;
		for (int p = 0; p < NETH; p++)
			t += rx_cnt[p];
		return t;
	endfunction

	task automatic check_value(input string name, input logic [BEATW-1:0] expected,
		input logic [BEATW-1:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	// First beat carries dst, src and the packet id in bytes 12 to 15
	task automatic send_packet(input int port, input mac_t dst, input int len);
		int id;
		int nb;
		int n;
		int k;
		id = next_id;
		next_id++;
		nb = (len + 15) / 16;
		test_ids.push_back(id);
		exp_len[id] = len;
		for (k = 0; k < nb; k++)
			exp_beat[id*MAXB + k] = (k == 0) ? {dst, port_mac(port), 32'(id)} :
				{$urandom, $urandom, $urandom, $urandom};
		@(negedge i_clk);
		// Lookup sees the table before this packet's own source is learned
		exp_mask[id] = expected_mask(port, dst);
		model_port[port_mac(port)] = port;
		model_time[port_mac(port)] = cycle;
		for (k = 0; k < nb; k++)
		begin
			if (k > 0)
				@(negedge i_clk);
			i_rx_valid[port] = 1'b1;
			i_rx_data[port*BEATW +: BEATW] = exp_beat[id*MAXB + k];
			i_rx_last[port] = (k == nb - 1);
			i_rx_bytes[port*BYTEW +: BYTEW] = (k == nb - 1) ? BYTEW'(len % 16) : '0;
			n = 0;
			do
			begin
				@(posedge i_clk);
				n++;
			end
			while (!o_rx_ready[port] && n < WAIT_LIMIT);
			if (!o_rx_ready[port])
			begin
				$display("Port %0d never accepted beat %0d of packet %0d", port, k, id);
				errors++;
				k = nb;
			end
		end
		@(negedge i_clk);
		i_rx_valid[port] = 1'b0;
		i_rx_last[port] = 1'b0;
	endtask

	//////////////////////////////
	// Monitors and comparison
	//////////////////////////////

	// Egress outputs are sampled at the rising edge, before they update
	always @(posedge i_clk)
	begin
		for (int p = 0; p < NETH; p++)
			if (i_rst_n && o_tx_valid[p] && i_tx_ready[p])
			begin
				if (cur_k[p] == 0)
					cur_id[p] = int'(o_tx_data[p*BEATW +: 32]);
				rx_beat[(cur_id[p]*NETH + p)*MAXB + cur_k[p]] = o_tx_data[p*BEATW +: BEATW];
				cur_k[p]++;
				if (o_tx_last[p])
				begin
					rx_len[cur_id[p]*NETH + p] = (cur_k[p] - 1) * 16 +
						((o_tx_bytes[p*BYTEW +: BYTEW] == '0) ? 16 :
						int'(o_tx_bytes[p*BYTEW +: BYTEW]));
					cur_k[p] = 0;
					rx_cnt[p]++;
				end
			end
	end

	always @(compare_req)
	begin
		int id;
		int key;
		logic [NETH-1:0] got;
		foreach (test_ids[i])
		begin
			id = test_ids[i];
			got = '0;
			for (int p = 0; p < NETH; p++)
				got[p] = rx_len.exists(id*NETH + p);
			check_value($sformatf("%s pkt %0d ports", test_name, id), BEATW'(exp_mask[id]),
				BEATW'(got));
			for (int p = 0; p < NETH; p++)
				if (exp_mask[id][p] && got[p])
				begin
					key = id*NETH + p;
					check_value($sformatf("%s pkt %0d len on %0d", test_name, id, p),
						BEATW'(exp_len[id]), BEATW'(rx_len[key]));
					for (int k = 0; k < (exp_len[id] + 15) / 16; k++)
						check_value($sformatf("%s pkt %0d beat %0d on %0d", test_name, id, k, p),
							exp_beat[id*MAXB + k],
							rx_beat.exists(key*MAXB + k) ? rx_beat[key*MAXB + k] : 'x);
				end
		end
		// Extra copies or leftovers from earlier tests show up here
		check_value({test_name, " packet count"}, BEATW'(want_total), BEATW'(rx_total()));
		compare_busy = 1'b0;
	end

	task automatic start_test(input string name);
		test_name = name;
		test_ids.delete();
		err_before = errors;
		for (int p = 0; p < NETH; p++)
			rx_cnt[p] = 0;
	endtask

	task automatic finish_test();
		int n;
		want_total = 0;
		foreach (test_ids[i])
			want_total += $countones(exp_mask[test_ids[i]]);
		n = 0;
		while (rx_total() < want_total && n < WAIT_LIMIT)
		begin
			@(negedge i_clk);
			n++;
		end
		if (rx_total() < want_total)
		begin
			$display("%s: only %0d of %0d packets reached the egress ports", test_name,
				rx_total(), want_total);
			errors++;
		end
		compare_busy = 1'b1;
		-> compare_req;
		n = 0;
		while (compare_busy && n < WAIT_LIMIT)
		begin
			@(negedge i_clk);
			n++;
		end
		if (compare_busy)
		begin
			$display("%s: comparison never finished", test_name);
			errors++;
		end
		tests_run++;
		if (errors == err_before)
		begin
			tests_passed++;
			$display("%s: ok", test_name);
		end
		else
			$display("%s: %0d errors", test_name, errors - err_before);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		seed = $urandom(SEED);
		i_rst_n = 1'b0;
		i_rx_valid = '0;
		i_rx_data = '0;
		i_rx_bytes = '0;
		i_rx_last = '0;
		i_tx_ready = '1;
		ready_random = 1'b0;
		compare_busy = 1'b0;
		cycle = 0;
		next_id = 1;
		errors = 0;
		tests_run = 0;
		tests_passed = 0;
		for (int p = 0; p < NETH; p++)
		begin
			rx_cnt[p] = 0;
			cur_k[p] = 0;
			cur_id[p] = 0;
		end
		repeat (2) @(negedge i_clk);
		i_rst_n = 1'b1;
		@(negedge i_clk);

		start_test("unknown_unicast");
		send_packet(1, MAC_U, 40);
		finish_test();

		// Port 2 owns A from here on
		start_test("learned_unicast");
		send_packet(2, port_mac(1), 20);
		send_packet(0, port_mac(2), 33);
		finish_test();

		// 37 bytes leave a 5 byte last beat
		start_test("broadcast");
		send_packet(1, BCAST_MAC, 37);
		finish_test();

		start_test("same_port_drop");
		send_packet(2, port_mac(2), 24);
		finish_test();

		// Refresh port 3, then three ports converge on it
		start_test("contention");
		send_packet(3, BCAST_MAC, 16);
		ready_random = 1'b1;
		fork
			for (int j = 0; j < 3; j++)
				send_packet(0, port_mac(3), 17 + int'($urandom % 24));
			for (int j = 0; j < 3; j++)
				send_packet(1, port_mac(3), 17 + int'($urandom % 24));
			for (int j = 0; j < 3; j++)
				send_packet(2, port_mac(3), 17 + int'($urandom % 24));
		join
		finish_test();
		ready_random = 1'b0;

		// No traffic from A long enough for its entry to age out
		start_test("ageing");
		repeat (3 << LGTIMEOUT) @(negedge i_clk);
		send_packet(0, port_mac(2), 50);
		finish_test();

		$display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run, tests_passed,
			tests_run - tests_passed, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// Hard stop if the sequence above hangs
	initial
	begin
		#200000;
		$display("Simulation ran past its time limit");
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
